// File: src/sdadc_pkg.sv
`default_nettype none

package sdadc_pkg;

    // CIC register width; every integrator and comb operation wraps at this size
    localparam int acc_width = 24;

    // Width of the signed sample held by the formatter
    localparam int result_width = 16;

    // Width of the data word presented on the output
    localparam int out_width = 32;

    // Width of the channel tag carried with each sample
    localparam int chan_width = 4;

    // One modulator bit as captured in the system clock domain
    typedef struct packed {
        logic value;
        logic strobe;
    } sd_bit_t;

    // Accumulator word with a one-cycle strobe
    // The integrator strobes every bit, the comb strobes every finished window
    typedef struct packed {
        logic [acc_width-1:0] value;
        logic                 strobe;
    } cic_word_t;

    // Output sample of the channel
    typedef struct packed {
        logic                  valid;
        logic [chan_width-1:0] channel;
        logic [out_width-1:0]  data;
    } sample_t;

endpackage

`default_nettype wire

// File: src/sd_bit_capture.sv
`timescale 1ns/1ps
`default_nettype none

module sd_bit_capture import sdadc_pkg::*; #(
    parameter bit sample_on_rise = 1'b1
) (
    input  logic    clock,
    input  logic    rst_n,
    input  logic    sd_clock_in,
    input  logic    sd_data_in,
    output sd_bit_t bit_out
);

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       sel_edge;
    logic       bit_value;
    logic       bit_strobe;

    // Two-flop synchronizers for the modulator clock and data
    // The edge detector compares against the synchronized level one cycle earlier
    always_ff @(posedge clock) begin
        clk_sync  <= {clk_sync[0], sd_clock_in};
        data_sync <= {data_sync[0], sd_data_in};
        clk_prev  <= clk_sync[1];
    end

    // Rising or falling edge of the synchronized modulator clock
    always_comb begin
        if (sample_on_rise) begin
            sel_edge = clk_sync[1] & ~clk_prev;
        end else begin
            sel_edge = ~clk_sync[1] & clk_prev;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bit_strobe <= 1'b0;
        end else begin
            bit_strobe <= sel_edge;
        end
    end

    // The data bit is taken on the same cycle the edge is seen
    always_ff @(posedge clock) begin
        if (sel_edge) begin
            bit_value <= data_sync[1];
        end
    end

    assign bit_out.value  = bit_value;
    assign bit_out.strobe = bit_strobe;

endmodule

`default_nettype wire

// File: src/cic_integrator.sv
`timescale 1ns/1ps
`default_nettype none

module cic_integrator import sdadc_pkg::*; #(
    parameter int cic_order = 3
) (
    input  logic      clock,
    input  logic      rst_n,
    input  sd_bit_t   bit_in,
    output cic_word_t acc_out
);

    logic [cic_order-1:0][acc_width-1:0] acc;
    logic                                acc_strobe;

    // All stages advance together on a bit strobe
    // Each later stage adds the value its predecessor held before this update
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (bit_in.strobe) begin
            acc[0] <= acc[0] + acc_width'(bit_in.value);
            for (int i = 1; i < cic_order; i++) begin
                acc[i] <= acc[i] + acc[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            acc_strobe <= 1'b0;
        end else begin
            acc_strobe <= bit_in.strobe;
        end
    end

    // Last stage is presented together with the delayed strobe
    assign acc_out.value  = acc[cic_order-1];
    assign acc_out.strobe = acc_strobe;

endmodule

`default_nettype wire

// File: src/cic_comb.sv
`timescale 1ns/1ps
`default_nettype none

module cic_comb import sdadc_pkg::*; #(
    parameter int cic_order  = 3,
    parameter int decimation = 64
) (
    input  logic      clock,
    input  logic      rst_n,
    input  cic_word_t acc_in,
    output cic_word_t comb_out
);

    localparam int cnt_width = (decimation > 1) ? $clog2(decimation) : 1;

    logic [cnt_width-1:0] bit_count;
    logic                 window_done;

    // Entry 0 is the captured integrator value, entry i+1 the output of comb stage i
    logic [cic_order:0][acc_width-1:0]   pipe_value;
    logic [cic_order:0]                  pipe_valid;
    logic [cic_order-1:0][acc_width-1:0] delay;

    assign window_done = acc_in.strobe && (bit_count == cnt_width'(decimation - 1));

    // Counts modulator bits within the current window
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bit_count <= '0;
        end else if (acc_in.strobe) begin
            if (window_done) begin
                bit_count <= '0;
            end else begin
                bit_count <= bit_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[cic_order-1:0], window_done};
        end
    end

    // Capture stage followed by one difference per cycle
    // Stages are independent, so a new window may enter while an older one drains
    always_ff @(posedge clock) begin
        if (window_done) begin
            pipe_value[0] <= acc_in.value;
        end
        for (int i = 0; i < cic_order; i++) begin
            if (pipe_valid[i]) begin
                pipe_value[i+1] <= pipe_value[i] - delay[i];
            end
        end
    end

    // Each delay register keeps its stage input from the previous window
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            delay <= '0;
        end else begin
            for (int i = 0; i < cic_order; i++) begin
                if (pipe_valid[i]) begin
                    delay[i] <= pipe_value[i];
                end
            end
        end
    end

    assign comb_out.value  = pipe_value[cic_order];
    assign comb_out.strobe = pipe_valid[cic_order];

endmodule

`default_nettype wire

// File: src/sample_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module sample_formatter import sdadc_pkg::*; #(
    parameter int output_shift  = 2,
    parameter int channel_index = 0
) (
    input  logic      clock,
    input  logic      rst_n,
    input  cic_word_t comb_in,
    input  logic      sync,
    output sample_t   sample_out
);

    localparam logic [result_width-1:0] full_scale = {1'b0, {(result_width-1){1'b1}}};
    localparam logic [result_width-1:0] mid_scale  = {1'b1, {(result_width-1){1'b0}}};

    logic [result_width:0]   shifted;
    logic [result_width-1:0] centred;
    logic [result_width-1:0] held;
    logic [out_width-1:0]    data_q;
    logic                    valid_q;

    // Unsigned comb result scaled into one bit more than the signed result
    assign shifted = (result_width+1)'(comb_in.value >> output_shift);

    // An overflow into the extra bit clamps to positive full scale,
    // otherwise the unsigned value is moved down by half the range
    always_comb begin
        if (shifted[result_width]) begin
            centred = full_scale;
        end else begin
            centred = shifted[result_width-1:0] - mid_scale;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            held <= '0;
        end else if (comb_in.strobe) begin
            held <= centred;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sync;
        end
    end

    // Data holds the sample seen at the sync edge, sign-extended to the output width
    always_ff @(posedge clock) begin
        if (sync) begin
            data_q <= {{(out_width-result_width){held[result_width-1]}}, held};
        end
    end

    assign sample_out.valid   = valid_q;
    assign sample_out.channel = chan_width'(channel_index);
    assign sample_out.data    = data_q;

endmodule

`default_nettype wire

// File: src/sdadc_channel.sv
`timescale 1ns/1ps
`default_nettype none

module sdadc_channel import sdadc_pkg::*; #(
    parameter int cic_order      = 3,
    parameter int decimation     = 64,
    parameter int output_shift   = 2,
    parameter bit sample_on_rise = 1'b1,
    parameter int channel_index  = 0
) (
    input  logic    clock,
    input  logic    rst_n,
    input  logic    sd_clock_in,
    input  logic    sd_data_in,
    input  logic    sync,
    output sample_t sample_out
);

    sd_bit_t   captured_bit;
    cic_word_t integrated;
    cic_word_t comb_result;

    // Modulator bits into the system clock domain
    sd_bit_capture #(
        .sample_on_rise(sample_on_rise)
    ) u_capture (
        .clock      (clock),
        .rst_n      (rst_n),
        .sd_clock_in(sd_clock_in),
        .sd_data_in (sd_data_in),
        .bit_out    (captured_bit)
    );

    cic_integrator #(
        .cic_order(cic_order)
    ) u_integrator (
        .clock  (clock),
        .rst_n  (rst_n),
        .bit_in (captured_bit),
        .acc_out(integrated)
    );

    // Decimation happens here by counting integrator strobes
    cic_comb #(
        .cic_order (cic_order),
        .decimation(decimation)
    ) u_comb (
        .clock   (clock),
        .rst_n   (rst_n),
        .acc_in  (integrated),
        .comb_out(comb_result)
    );

    sample_formatter #(
        .output_shift (output_shift),
        .channel_index(channel_index)
    ) u_formatter (
        .clock     (clock),
        .rst_n     (rst_n),
        .comb_in   (comb_result),
        .sync      (sync),
        .sample_out(sample_out)
    );

endmodule

`default_nettype wire

// File: tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Arithmetic of the CIC chain and the formatter, with no cycle timing
localparam int model_order = 3;
localparam int model_decim = 64;
localparam int model_shift = 2;

logic [model_order-1:0][acc_width-1:0] model_integ;
logic [model_order-1:0][acc_width-1:0] model_delay;
logic [result_width-1:0]               model_held;
int                                    model_bits;

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Shift, clamp on overflow into bit 16, then move down by half the range
function automatic logic [result_width-1:0] format_result(input logic [acc_width-1:0] comb);
    logic [result_width:0] scaled;
    scaled = (result_width+1)'(comb >> model_shift);
    if (scaled[result_width]) begin
        return 16'h7fff;
    end
    return scaled[result_width-1:0] - 16'h8000;
endfunction

function automatic logic [out_width-1:0] expected_word(input logic [result_width-1:0] held);
    return {{(out_width-result_width){held[result_width-1]}}, held};
endfunction

task automatic reset_model();
    model_integ = '0;
    model_delay = '0;
    model_held  = '0;
    model_bits  = 0;
endtask

// One modulator bit through the integrators, and a comb pass when a window closes
task automatic push_model_bit(input logic b);
    logic [model_order-1:0][acc_width-1:0] old;
    logic [acc_width-1:0]                  x;
    logic [acc_width-1:0]                  y;
    old = model_integ;
    model_integ[0] = old[0] + acc_width'(b);
    for (int i = 1; i < model_order; i++) begin
        model_integ[i] = old[i] + old[i-1];
    end
    model_bits++;
    if (model_bits == model_decim) begin
        model_bits = 0;
        x = model_integ[model_order-1];
        for (int i = 0; i < model_order; i++) begin
            y = x - model_delay[i];
            model_delay[i] = x;
            x = y;
        end
        model_held = format_result(x);
    end
endtask

`endif

// File: tests/tb_sdadc_channel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdadc_channel import sdadc_pkg::*; ();

    localparam int max_cycles = 40000;

    logic    clock;
    logic    rst_n;
    logic    sd_clock_in;
    logic    sd_data_in;
    logic    sync;
    sample_t sample_out;

    int                   error_count;
    logic [31:0]          rng_state;
    logic [out_width-1:0] exp_q [$];
    logic                 prev_sync;
    logic                 prev_rst_n;

    `include "tb_ref_model.svh"

    sdadc_channel u_dut (
        .clock      (clock),
        .rst_n      (rst_n),
        .sd_clock_in(sd_clock_in),
        .sd_data_in (sd_data_in),
        .sync       (sync),
        .sample_out (sample_out)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    function automatic logic next_bit(input int mode);
        if (mode == 0) begin
            return 1'b0;
        end
        if (mode == 1) begin
            return 1'b1;
        end
        rng_state = xorshift32(rng_state);
        return rng_state[0];
    endfunction

    // One modulator period of 8 clocks, data changes with the falling edge
    task automatic send_bit(input logic b, input logic do_sync, input logic [31:0] want);
        sd_clock_in = 1'b0;
        sd_data_in  = b;
        if (do_sync) begin
            exp_q.push_back(want);
            sync = 1'b1;
        end
        step_cycles(1);
        sync = 1'b0;
        step_cycles(3);
        sd_clock_in = 1'b1;
        step_cycles(4);
        push_model_bit(b);
    endtask

    // Sync at bit 2 reports the window before, well clear of the pipeline latency
    task automatic run_windows(input int count, input int mode, input bit double_sync);
        logic        b;
        logic [31:0] want;
        for (int w = 0; w < count; w++) begin
            for (int k = 0; k < model_decim; k++) begin
                b = next_bit(mode);
                if (k == 2 || (double_sync && k == 20)) begin
                    if (mode != 2 && w >= 3) begin
                        // A constant stream has settled from its third window on
                        want = (mode == 0) ? 32'hffff8000 : 32'h00007fff;
                    end else begin
                        want = expected_word(model_held);
                    end
                    send_bit(b, 1'b1, want);
                end else begin
                    send_bit(b, 1'b0, '0);
                end
            end
        end
    endtask

    initial begin : stimulus
        int waited;
        error_count = 0;
        rng_state   = 32'h78ba;
        rst_n       = 1'b0;
        sd_clock_in = 1'b0;
        sd_data_in  = 1'b0;
        sync        = 1'b0;
        reset_model();
        step_cycles(5);
        rst_n = 1'b1;
        run_windows(5, 0, 1'b0);
        run_windows(5, 1, 1'b0);
        run_windows(41, 2, 1'b0);
        run_windows(2, 2, 1'b1);
        // Reset in the middle of a window, then start over from a clean model
        for (int k = 0; k < 30; k++) begin
            send_bit(next_bit(2), 1'b0, '0);
        end
        step_cycles(4);
        rst_n = 1'b0;
        step_cycles(2);
        // A sync while reset is held must leave valid low
        sync = 1'b1;
        step_cycles(1);
        sync = 1'b0;
        step_cycles(2);
        rst_n = 1'b1;
        reset_model();
        step_cycles(3);
        run_windows(3, 2, 1'b0);
        send_bit(1'b0, 1'b0, '0);
        send_bit(1'b0, 1'b0, '0);
        send_bit(1'b0, 1'b1, expected_word(model_held));
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            step_cycles(1);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Expected samples were left unchecked at the end of the run");
            error_count++;
        end
        step_cycles(4);
        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Each queued sync must produce one valid sample within 4 cycles
    initial begin : compare
        logic [31:0] want;
        int          waited;
        forever begin
            @(negedge clock);
            if (exp_q.size() != 0) begin
                want   = exp_q[0];
                waited = 0;
                while (!sample_out.valid && waited < 4) begin
                    @(negedge clock);
                    waited++;
                end
                if (!sample_out.valid) begin
                    $display("No valid sample within 4 cycles of sync at %0t", $time);
                    error_count++;
                end else begin
                    if (sample_out.data !== want) begin
                        $display("** Error sample_out.data: got %h, expected %h at %0t",
                                 sample_out.data, want, $time);
                        error_count++;
                    end
                    if (sample_out.channel !== 4'h0) begin
                        $display("** Error sample_out.channel: got %h, expected %h at %0t",
                                 sample_out.channel, 4'h0, $time);
                        error_count++;
                    end
                end
                void'(exp_q.pop_front());
            end
        end
    end

    // Valid is high only in the cycle after a sync taken outside reset
    initial begin : valid_monitor
        logic exp_valid;
        prev_sync  = 1'b0;
        prev_rst_n = 1'b0;
        forever begin
            @(negedge clock);
            exp_valid = prev_sync && prev_rst_n;
            if (sample_out.valid !== exp_valid) begin
                $display("** Error sample_out.valid: got %h, expected %h at %0t",
                         sample_out.valid, exp_valid, $time);
                error_count++;
            end
            prev_sync  = sync;
            prev_rst_n = rst_n;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clock);
            cycles++;
        end
        $display("Run stopped after reaching the limit of %0d cycles", max_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+tests
src/sdadc_pkg.sv
src/sd_bit_capture.sv
src/cic_integrator.sv
src/cic_comb.sv
src/sample_formatter.sv
src/sdadc_channel.sv
tests/tb_sdadc_channel.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_sdadc_channel
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Failure found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
